//--- common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

//////////////////////////////////////////////////
// frame and queue sizing
//////////////////////////////////////////////////

// bits carried between the start and stop bit
`define UART_DATA_BITS 8

// entries in each of the tx and rx queues, kept a power of two
`define UART_FIFO_DEPTH 8

// bit period in clk cycles right after reset
`define UART_DEFAULT_DIV 16

// shortest bit period the receiver can still center on
`define UART_MIN_DIV 4

`endif

//--- common/uart_pkg.sv
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////

    localparam logic [1:0] ADDR_DATA = 2'd0; // tx push on write, rx pop on read
    localparam logic [1:0] ADDR_CTRL = 2'd1; // control on write, status on read
    localparam logic [1:0] ADDR_DIV  = 2'd2; // bit period in clk cycles

    typedef logic [15:0] div_t;

    // write view of ADDR_CTRL
    typedef struct packed {
        logic [28:0] reserved;
        logic        err_clear;  // drops all three sticky errors
        logic        tx_flush;
        logic        rx_flush;
    } ctrl_t;

    // read view of ADDR_CTRL
    typedef struct packed {
        logic [23:0] zero;
        logic        tx_overflow; // host wrote while the tx queue was full
        logic        rx_overrun;  // a byte arrived while the rx queue was full
        logic        frame_err;   // a stop bit was sampled low
        logic        tx_busy;
        logic        rx_full;
        logic        rx_empty;
        logic        tx_full;
        logic        tx_empty;
    } stat_t;

    // one address carries both views
    typedef union packed {
        ctrl_t ctrl;
        stat_t stat;
    } ctrl_stat_u;

endpackage

`default_nettype wire

//--- common/uart_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

interface uart_ctrl_if;

    uart_pkg::div_t             divisor;      // bit period for both directions
    logic [`UART_DATA_BITS-1:0] tx_data;      // head of the tx queue
    logic                       tx_valid;     // tx queue holds a byte
    logic                       tx_ready;     // serializer is idle
    logic                       tx_busy;
    logic [`UART_DATA_BITS-1:0] rx_data;
    logic                       rx_valid;     // one cycle per good frame
    logic                       rx_frame_err; // one cycle per bad stop bit

    modport regs (
        output divisor,
        output tx_data,
        output tx_valid,
        input  tx_ready,
        input  tx_busy,
        input  rx_data,
        input  rx_valid,
        input  rx_frame_err
    );

    modport tx (
        input  divisor,
        input  tx_data,
        input  tx_valid,
        output tx_ready,
        output tx_busy
    );

    modport rx (
        input  divisor,
        output rx_data,
        output rx_valid,
        output rx_frame_err
    );

endinterface

`default_nettype wire

//--- rtl/uart_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_push,
    input  wire [WIDTH-1:0]  i_data,
    input  wire              i_pop,
    input  wire              i_flush,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;  // a push into a full queue is lost
    assign do_pop  = i_pop && !o_empty;
    assign o_data  = mem[rd_ptr];         // head is visible before the pop
    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // pointers wrap since DEPTH is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // the level must stay consistent with the pointers across push, pop and flush
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (AW+1)'(DEPTH) && count[AW-1:0] == AW'(wr_ptr - rd_ptr));

endmodule

`default_nettype wire

//--- rtl/uart_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uart_regs (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_wb_cyc,
    input  wire         i_wb_stb,
    input  wire         i_wb_we,
    input  wire [3:0]   i_wb_adr,
    input  wire [31:0]  i_wb_dat,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack,
    uart_ctrl_if.regs   ctrl
);

    localparam int DW = `UART_DATA_BITS;

    logic                 bus_req;
    logic                 wr_en;
    logic                 rd_en;
    logic [1:0]           word_adr;
    logic                 aligned;
    uart_pkg::ctrl_stat_u wr_view;
    uart_pkg::ctrl_stat_u stat_view;
    uart_pkg::div_t       wr_div;
    uart_pkg::div_t       divisor_q;
    logic                 ctrl_wr;
    logic                 tx_push;
    logic                 tx_pop;
    logic                 tx_empty;
    logic                 tx_full;
    logic                 rx_pop;
    logic [DW-1:0]        rx_head;
    logic                 rx_empty;
    logic                 rx_full;
    logic                 frame_err;
    logic                 rx_overrun;
    logic                 tx_overflow;
    logic [31:0]          rd_word;

    //////////////////////////////////////////////////
    // bus decode
    //////////////////////////////////////////////////

    assign bus_req  = i_wb_cyc && i_wb_stb && !o_wb_ack; // ack drops for a cycle between accesses
    assign word_adr = i_wb_adr[3:2];
    assign aligned  = (i_wb_adr[1:0] == 2'b00); // byte offsets count as unknown addresses
    assign wr_en    = bus_req && i_wb_we && aligned;
    assign rd_en    = bus_req && !i_wb_we && aligned;
    assign wr_view  = i_wb_dat;
    assign wr_div   = i_wb_dat[15:0];
    assign ctrl_wr  = wr_en && (word_adr == uart_pkg::ADDR_CTRL);
    assign tx_push  = wr_en && (word_adr == uart_pkg::ADDR_DATA);
    assign rx_pop   = rd_en && (word_adr == uart_pkg::ADDR_DATA);
    assign tx_pop   = !tx_empty && ctrl.tx_ready;

    assign ctrl.divisor  = divisor_q;
    assign ctrl.tx_valid = !tx_empty;

    uart_fifo #(.WIDTH(DW), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (tx_push),
        .i_data  (i_wb_dat[DW-1:0]),
        .i_pop   (tx_pop),
        .i_flush (ctrl_wr && wr_view.ctrl.tx_flush),
        .o_data  (ctrl.tx_data),
        .o_empty (tx_empty),
        .o_full  (tx_full)
    );

    uart_fifo #(.WIDTH(DW), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (ctrl.rx_valid),
        .i_data  (ctrl.rx_data),
        .i_pop   (rx_pop),
        .i_flush (ctrl_wr && wr_view.ctrl.rx_flush),
        .o_data  (rx_head),
        .o_empty (rx_empty),
        .o_full  (rx_full)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_ack    <= 1'b0;
            divisor_q   <= uart_pkg::div_t'(`UART_DEFAULT_DIV);
            frame_err   <= 1'b0;
            rx_overrun  <= 1'b0;
            tx_overflow <= 1'b0;
        end else begin
            o_wb_ack <= bus_req;
            if (wr_en && word_adr == uart_pkg::ADDR_DIV) begin
                divisor_q <= (wr_div < uart_pkg::div_t'(`UART_MIN_DIV)) ?
                             uart_pkg::div_t'(`UART_MIN_DIV) : wr_div;
            end
            if (ctrl_wr && wr_view.ctrl.err_clear) begin
                frame_err   <= 1'b0;
                rx_overrun  <= 1'b0;
                tx_overflow <= 1'b0;
            end
            if (ctrl.rx_frame_err) begin
                frame_err <= 1'b1;
            end
            if (ctrl.rx_valid && rx_full) begin
                rx_overrun <= 1'b1; // the incoming byte is dropped by the FIFO
            end
            if (tx_push && tx_full) begin
                tx_overflow <= 1'b1;
            end
        end
    end

    always_comb begin
        stat_view                  = '0;
        stat_view.stat.tx_empty    = tx_empty;
        stat_view.stat.tx_full     = tx_full;
        stat_view.stat.rx_empty    = rx_empty;
        stat_view.stat.rx_full     = rx_full;
        stat_view.stat.tx_busy     = ctrl.tx_busy;
        stat_view.stat.frame_err   = frame_err;
        stat_view.stat.rx_overrun  = rx_overrun;
        stat_view.stat.tx_overflow = tx_overflow;
    end

    always_comb begin
        case (word_adr)
            uart_pkg::ADDR_DATA: rd_word = rx_empty ? '0 : {{(32-DW){1'b0}}, rx_head};
            uart_pkg::ADDR_CTRL: rd_word = stat_view;
            uart_pkg::ADDR_DIV:  rd_word = {16'h0000, divisor_q};
            default:             rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            o_wb_dat <= rd_word;
        end else if (bus_req) begin
            o_wb_dat <= '0; // writes and unknown reads return zero
        end
    end

    // every ack answers a request seen on the previous edge
    a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uart_tx (
    input  wire     clk,
    input  wire     rst,
    output logic    o_txd,
    uart_ctrl_if.tx ctrl
);

    localparam int FRAME_BITS = `UART_DATA_BITS + 2; // start, data, stop

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

    tx_state_t             state;
    logic [FRAME_BITS-1:0] frame_q;
    logic [3:0]            bit_idx;
    uart_pkg::div_t        timer;
    uart_pkg::div_t        div_q;
    logic                  accept;

    assign accept        = ctrl.tx_valid && ctrl.tx_ready;
    assign ctrl.tx_ready = (state == TX_IDLE);
    assign ctrl.tx_busy  = (state == TX_SEND);
    assign o_txd         = frame_q[0]; // line comes straight from a flop

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            frame_q <= '1;
            bit_idx <= '0;
            timer   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        frame_q <= {1'b1, ctrl.tx_data, 1'b0};
                        bit_idx <= '0;
                        timer   <= ctrl.divisor - 1'b1;
                        state   <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]}; // idle level fills from the top
                        timer   <= div_q - 1'b1;
                        if (bit_idx == 4'(FRAME_BITS - 1)) begin
                            state <= TX_IDLE; // stop bit has run its full period
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // a divisor change mid frame waits for the next byte
    always_ff @(posedge clk) begin
        if (accept) begin
            div_q <= ctrl.divisor;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
        !ctrl.tx_busy |-> o_txd);

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uart_rx (
    input  wire     clk,
    input  wire     rst,
    input  wire     i_rxd,
    uart_ctrl_if.rx ctrl
);

    localparam int DW = `UART_DATA_BITS;
    localparam int BW = (DW > 1) ? $clog2(DW) : 1;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t      state;
    logic           rxd_meta;
    logic           rxd_sync;
    logic           rxd_prev;
    logic           fall;
    logic [BW-1:0]  bit_idx;
    uart_pkg::div_t timer;
    uart_pkg::div_t div_q;
    logic [DW-1:0]  shift_q;
    logic           valid_q;
    logic           ferr_q;

    //////////////////////////////////////////////////
    // line synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync; // kept only for edge detection
        end
    end

    assign fall              = rxd_prev && !rxd_sync;
    assign ctrl.rx_data      = shift_q;
    assign ctrl.rx_valid     = valid_q;
    assign ctrl.rx_frame_err = ferr_q;

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            bit_idx <= '0;
            timer   <= '0;
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        timer <= (ctrl.divisor >> 1) - 1'b1; // aim at the middle of the start bit
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (rxd_sync) begin
                        state <= RX_IDLE; // short low pulse on the line
                    end else begin
                        timer   <= div_q - 1'b1;
                        bit_idx <= '0;
                        state   <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        timer <= div_q - 1'b1;
                        if (bit_idx == BW'(DW - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        valid_q <= rxd_sync;
                        ferr_q  <= !rxd_sync; // no byte goes out for a broken frame
                        state   <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_IDLE && fall) begin
            div_q <= ctrl.divisor;
        end
        if (state == RX_DATA && timer == '0) begin
            shift_q <= {rxd_sync, shift_q[DW-1:1]}; // lsb arrives first
        end
    end

    // a frame ends in exactly one of the two outcomes
    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.rx_valid && ctrl.rx_frame_err));

endmodule

`default_nettype wire

//--- rtl/uart_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_wb_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_wb_cyc,
    input  wire         i_wb_stb,
    input  wire         i_wb_we,
    input  wire [3:0]   i_wb_adr,
    input  wire [31:0]  i_wb_dat,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack,
    input  wire         i_rxd,
    output logic        o_txd
);

    uart_ctrl_if u_ctrl_if ();

    uart_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .ctrl     (u_ctrl_if.regs)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst   (rst),
        .o_txd (o_txd),
        .ctrl  (u_ctrl_if.tx)
    );

    uart_rx u_rx (
        .clk   (clk),
        .rst   (rst),
        .i_rxd (i_rxd),
        .ctrl  (u_ctrl_if.rx)
    );

endmodule

`default_nettype wire

//--- tb/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_settings.svh"

module uart_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int SEED         = 66383;
    localparam int MAX_DIV      = 40;
    localparam int DW           = `UART_DATA_BITS;
    localparam int DEPTH        = `UART_FIFO_DEPTH;
    localparam int TX_ROUNDS    = 4;
    localparam int TX_PER_ROUND = 3;
    localparam int RX_BYTES     = 6;
    localparam int N_FRAMES     = TX_ROUNDS * TX_PER_ROUND + RX_BYTES + 1 + 2 * (DEPTH + 2);
    localparam logic [3:0] A_DATA = 4'h0; // word addresses sit on bits 3:2
    localparam logic [3:0] A_CTRL = 4'h4;
    localparam logic [3:0] A_DIV  = 4'h8;

    logic          clk;
    logic          rst;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [3:0]    wb_adr;
    logic [31:0]   wb_wdat;
    logic [31:0]   wb_rdat;
    logic          wb_ack;
    logic          rxd;
    logic          txd;
    int            errors;
    int            line_div;      // divisor the DUT holds, mirrored on every DIV write
    int            tx_starts;     // frame starts seen on the tx line
    logic [DW-1:0] exp_tx[$];
    logic [DW-1:0] got_tx[$];
    logic [DW-1:0] exp_rx[$];
    logic          exp_frame_err;
    logic          exp_overrun;
    logic          exp_overflow;

    uart_wb_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_wdat),
        .o_wb_dat (wb_rdat),
        .o_wb_ack (wb_ack),
        .i_rxd    (rxd),
        .o_txd    (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // bus and line tasks
    //////////////////////////////////////////////////

    // ack is due on the first clock edge after the request
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack && cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        check(32'(cycles), 32'(1), "ack latency in clocks");
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= 1'b1;
        wb_adr  <= adr;
        wb_wdat <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check(32'(wb_ack), 32'(0), "ack drops after one cycle");
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_rdat; // o_wb_dat is valid while ack is high
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        check(32'(wb_ack), 32'(0), "ack drops after one cycle");
    endtask

    task automatic set_divisor(input int value);
        logic [31:0] rdat;
        int          stored;
        stored = (value < `UART_MIN_DIV) ? `UART_MIN_DIV : value;
        bus_write(A_DIV, 32'(value));
        bus_read(A_DIV, rdat);
        check(rdat, 32'(stored), "divisor readback");
        line_div = stored;
    endtask

    // reads status and compares the sticky bits with the model
    task automatic check_sticky(output logic [31:0] stat);
        bus_read(A_CTRL, stat);
        check(32'(stat[5]), 32'(exp_frame_err), "frame_err");
        check(32'(stat[6]), 32'(exp_overrun), "rx_overrun");
        check(32'(stat[7]), 32'(exp_overflow), "tx_overflow");
    endtask

    task automatic wait_tx_idle();
        logic [31:0] stat;
        stat = '0;
        while (!(stat[0] && !stat[4])) begin
            bus_read(A_CTRL, stat);
        end
    endtask

    task automatic compare_tx();
        check(32'(got_tx.size()), 32'(exp_tx.size()), "tx frame count");
        while (exp_tx.size() > 0 && got_tx.size() > 0) begin
            check(32'(got_tx.pop_front()), 32'(exp_tx.pop_front()), "tx byte");
        end
        exp_tx.delete();
        got_tx.delete();
    endtask

    task automatic send_frame(input logic [DW-1:0] data, input logic bad_stop);
        logic [DW+1:0] frame;
        int            i;
        frame = {!bad_stop, data, 1'b0};
        for (i = 0; i < DW + 2; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (line_div - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1;
        repeat (line_div) @(posedge clk); // idle gap covers the rx stop sample
    endtask

    // decodes frames on the tx line at mid-bit, on falling clock edges
    initial begin : line_monitor
        logic [DW-1:0] data;
        int            div;
        int            i;
        @(negedge rst);
        forever begin
            @(negedge txd);
            div = line_div;
            tx_starts++;
            repeat (div / 2) @(negedge clk);
            check(32'(txd), 32'(0), "tx start bit");
            for (i = 0; i < DW; i++) begin
                repeat (div) @(negedge clk);
                data[i] = txd;
            end
            repeat (div) @(negedge clk);
            check(32'(txd), 32'(1), "tx stop bit");
            got_tx.push_back(data);
        end
    end

    initial begin : watchdog
        #(N_FRAMES * 10 * MAX_DIV * CLK_PERIOD * 3);
        $display("timeout: the run did not finish in time, %0d errors so far", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin : main
        logic [31:0]   rdat;
        logic [DW-1:0] b;
        logic [DW-1:0] accepted[$];
        int            n;
        int            r;
        int            base_starts;
        int            level;
        void'($urandom(SEED));
        errors        = 0;
        line_div      = `UART_DEFAULT_DIV;
        tx_starts     = 0;
        exp_frame_err = 1'b0;
        exp_overrun   = 1'b0;
        exp_overflow  = 1'b0;
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_wdat       = '0;
        rxd           = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset state
        bus_read(A_DIV, rdat);
        check(rdat, 32'(`UART_DEFAULT_DIV), "reset divisor");
        check_sticky(rdat);
        check(32'(rdat[4:0]), 32'h05, "reset queue flags"); // tx_empty and rx_empty only
        @(negedge clk);
        check(32'(txd), 32'(1), "idle tx line");
        bus_read(A_DATA, rdat);
        check(rdat, 32'h0, "empty rx read");

        // transmit at random divisors, the first one below the minimum
        for (r = 0; r < TX_ROUNDS; r++) begin
            set_divisor((r == 0) ? 2 : int'($urandom_range(MAX_DIV, `UART_MIN_DIV)));
            for (n = 0; n < TX_PER_ROUND; n++) begin
                b = DW'($urandom);
                exp_tx.push_back(b);
                bus_write(A_DATA, 32'(b));
            end
            wait_tx_idle();
            compare_tx();
        end

        // receive
        set_divisor(int'($urandom_range(MAX_DIV, `UART_MIN_DIV)));
        for (n = 0; n < RX_BYTES; n++) begin
            b = DW'($urandom);
            exp_rx.push_back(b);
            send_frame(b, 1'b0);
        end
        for (n = 0; n < RX_BYTES; n++) begin
            bus_read(A_DATA, rdat);
            check(rdat, 32'(exp_rx.pop_front()), "rx byte");
        end
        check_sticky(rdat);
        check(32'(rdat[2]), 32'(1), "rx_empty after drain");

        // framing error
        send_frame(DW'($urandom), 1'b1);
        exp_frame_err = 1'b1;
        check_sticky(rdat);
        check(32'(rdat[2]), 32'(1), "rx_empty after bad frame");
        bus_write(A_CTRL, 32'h4);
        exp_frame_err = 1'b0;
        check_sticky(rdat);

        // rx overrun
        for (n = 0; n < DEPTH + 2; n++) begin
            b = DW'($urandom);
            if (exp_rx.size() < DEPTH) begin
                exp_rx.push_back(b);
            end else begin
                exp_overrun = 1'b1;
            end
            send_frame(b, 1'b0);
        end
        check_sticky(rdat);
        check(32'(rdat[3]), 32'(1), "rx_full");
        while (exp_rx.size() > 0) begin
            bus_read(A_DATA, rdat);
            check(rdat, 32'(exp_rx.pop_front()), "rx byte after overrun");
        end
        bus_write(A_CTRL, 32'h4);
        exp_overrun = 1'b0;
        check_sticky(rdat);

        // tx overflow and flush
        set_divisor(MAX_DIV);
        base_starts = tx_starts;
        for (n = 0; n < DEPTH + 2; n++) begin
            b = DW'($urandom);
            level = accepted.size() - (tx_starts - base_starts); // each frame start is one pop
            if (level < DEPTH) begin
                accepted.push_back(b);
            end else begin
                exp_overflow = 1'b1;
            end
            bus_write(A_DATA, 32'(b));
        end
        level = accepted.size() - (tx_starts - base_starts);
        check_sticky(rdat);
        check(32'(rdat[1]), 32'(level == DEPTH), "tx_full");
        bus_write(A_CTRL, 32'h2);
        for (n = 0; n < tx_starts - base_starts; n++) begin
            exp_tx.push_back(accepted[n]);
        end
        check_sticky(rdat);
        check(32'(rdat[0]), 32'(1), "tx_empty after flush");
        wait_tx_idle();
        compare_tx();
        bus_write(A_CTRL, 32'h4);
        exp_overflow = 1'b0;
        check_sticky(rdat);

        $display("uart_tb done: %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/uart_pkg.sv
common/uart_ctrl_if.sv
rtl/uart_fifo.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_wb_top.sv
tb/uart_tb.sv

//--- Makefile
# Verilator flow for the UART Wishbone peripheral

TOP := uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module uart_wb_top

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
